//--- common/bus_fab_pkg.sv
/* Channel payload types and exception codes of the shared-bus fabric.
   Imported by the fabric RTL and by the testbench. */

package bus_fab_pkg;

    // ************************************************************
    // bus widths
    // ************************************************************
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;

    // response exception code
    typedef enum logic [1:0] {
        EXCP_NONE      = 2'd0,
        EXCP_ACC_FAULT = 2'd1,
        EXCP_SLV_ERR   = 2'd2
    } bus_excp_e;

    // request payload, 69 bits
    typedef struct packed {
        logic              read;
        logic [ADDR_W-1:0] addr;
        logic [MASK_W-1:0] mask;
        logic [DATA_W-1:0] data;
    } bus_req_t;

    // response payload, 34 bits
    typedef struct packed {
        bus_excp_e         excp;
        logic [DATA_W-1:0] data;
    } bus_rsp_t;

endpackage

//--- common/bus_map_pkg.sv
/* Address map of the fabric: region select field and slave base values. */

package bus_map_pkg;

    // region select sits in the top address nibble
    localparam int REGION_LSB = 28;
    localparam int REGION_W   = 4;

    // largest slave count the map can describe
    localparam int MAX_SLV = 16;

    // base value per slave, slave s decodes region s
    localparam logic [MAX_SLV-1:0][REGION_W-1:0] SLV_BASE = {
        4'hf, 4'he, 4'hd, 4'hc, 4'hb, 4'ha, 4'h9, 4'h8,
        4'h7, 4'h6, 4'h5, 4'h4, 4'h3, 4'h2, 4'h1, 4'h0
    };

endpackage

//--- hw/bus_fab/rr_arbiter.sv
/* Round-robin arbiter, combinational from request to one-hot grant.
   The priority pointer moves past the granted master on the next edge. */

`timescale 1ns/1ns

module rr_arbiter #(
    parameter int MST_NUM = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [MST_NUM-1:0] req,
    output logic [MST_NUM-1:0] grant
);

    // pointer as a thermometer mask, bits at or above it are set
    logic [MST_NUM-1:0] pri_mask;
    logic [MST_NUM-1:0] req_masked;
    logic [MST_NUM-1:0] grant_masked;
    logic [MST_NUM-1:0] grant_plain;

    assign req_masked = req & pri_mask;

    // lowest set bit, first requester at or after the pointer
    assign grant_masked = req_masked & (~req_masked + MST_NUM'(1));
    // wrap around when nobody sits above the pointer
    assign grant_plain  = req & (~req + MST_NUM'(1));

    assign grant = (|req_masked) ? grant_masked : grant_plain;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pri_mask <= '1;
        end else if (|grant) begin
            // keep only bits above the winner
            pri_mask <= ~((grant << 1) - MST_NUM'(1));
        end
    end

endmodule

//--- hw/bus_fab/addr_decode.sv
/* Address decoder: per master, the slave match vector and the flag for
   a valid request that hits no slave region. */

`timescale 1ns/1ns

module addr_decode
    import bus_fab_pkg::*;
    import bus_map_pkg::*;
#(
    parameter int MST_NUM = 3,
    parameter int SLV_NUM = 4
) (
    input  logic     [MST_NUM-1:0]              mst_req_vld,
    input  bus_req_t [MST_NUM-1:0]              mst_req,
    output logic     [MST_NUM-1:0][SLV_NUM-1:0] addr_match,
    output logic     [MST_NUM-1:0]              acc_fault
);

    always_comb begin
        for (int m = 0; m < MST_NUM; m++) begin
            for (int s = 0; s < SLV_NUM; s++) begin
                addr_match[m][s] = mst_req[m].addr[REGION_LSB +: REGION_W] == SLV_BASE[s];
            end
            // unmapped region
            acc_fault[m] = mst_req_vld[m] & ~(|addr_match[m]);
        end
    end

endmodule

//--- hw/bus_fab/bus_fab_ctrl.sv
/* Grant and lock control of the fabric. Forms arbiter requests from the
   lock rule, runs one round-robin arbiter per slave and holds the grants. */

`timescale 1ns/1ns

module bus_fab_ctrl #(
    parameter int MST_NUM = 3,
    parameter int SLV_NUM = 4
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [MST_NUM-1:0]              mst_req_vld,
    input  logic [MST_NUM-1:0][SLV_NUM-1:0] addr_match,
    input  logic [SLV_NUM-1:0]              slv_rsp_fire,
    output logic [MST_NUM-1:0][SLV_NUM-1:0] req_lock,
    output logic [MST_NUM-1:0][SLV_NUM-1:0] rsp_lock
);

    // arbiter side, indexed [slv][mst]
    logic [SLV_NUM-1:0][MST_NUM-1:0] arb_req;
    logic [SLV_NUM-1:0][MST_NUM-1:0] arb_grant;
    // master side, indexed [mst][slv]
    logic [MST_NUM-1:0][SLV_NUM-1:0] mst_grant;
    logic [MST_NUM-1:0][SLV_NUM-1:0] grant_r;

    logic [SLV_NUM-1:0] slv_free;
    logic [MST_NUM-1:0] mst_free;

    // ************************************************************
    // lock rule
    // ************************************************************
    // slave is free with no held grant, or when the held one completes
    always_comb begin
        for (int s = 0; s < SLV_NUM; s++) begin
            slv_free[s] = 1'b1;
            for (int m = 0; m < MST_NUM; m++) begin
                if (grant_r[m][s] && !slv_rsp_fire[s]) begin
                    slv_free[s] = 1'b0;
                end
            end
        end
    end

    // one outstanding request per master
    always_comb begin
        for (int m = 0; m < MST_NUM; m++) begin
            mst_free[m] = ~(|grant_r[m]) | (|(grant_r[m] & slv_rsp_fire));
        end
    end

    always_comb begin
        for (int s = 0; s < SLV_NUM; s++) begin
            for (int m = 0; m < MST_NUM; m++) begin
                arb_req[s][m] = mst_req_vld[m] & addr_match[m][s] & slv_free[s] & mst_free[m];
            end
        end
    end

    for (genvar s = 0; s < SLV_NUM; s++) begin : g_arb
        rr_arbiter #(.MST_NUM(MST_NUM)) u_arb (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (arb_req[s]),
            .grant (arb_grant[s])
        );
    end

    always_comb begin
        for (int m = 0; m < MST_NUM; m++) begin
            for (int s = 0; s < SLV_NUM; s++) begin
                mst_grant[m][s] = arb_grant[s][m];
            end
        end
    end

    // ************************************************************
    // grant registers, held until the paired response fires
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_r <= '0;
        end else begin
            for (int m = 0; m < MST_NUM; m++) begin
                if (|mst_grant[m]) begin
                    grant_r[m] <= mst_grant[m];
                end else if (|(grant_r[m] & slv_rsp_fire)) begin
                    grant_r[m] <= '0;
                end
            end
        end
    end

    // new grant this cycle, or a held one not completing now
    always_comb begin
        for (int m = 0; m < MST_NUM; m++) begin
            req_lock[m] = mst_grant[m] | (grant_r[m] & ~slv_rsp_fire);
        end
    end

    assign rsp_lock = grant_r;

endmodule

//--- hw/bus_fab/req_router.sv
/* Request path: steers each locked master's valid and payload to its
   slave and returns that slave's ready. Faulting masters get ready at once. */

`timescale 1ns/1ns

module req_router
    import bus_fab_pkg::*;
#(
    parameter int MST_NUM = 3,
    parameter int SLV_NUM = 4
) (
    input  logic     [MST_NUM-1:0][SLV_NUM-1:0] req_lock,
    input  logic     [MST_NUM-1:0]              mst_req_vld,
    input  bus_req_t [MST_NUM-1:0]              mst_req,
    input  logic     [SLV_NUM-1:0]              slv_req_rdy,
    input  logic     [MST_NUM-1:0]              acc_fault,
    output logic     [SLV_NUM-1:0]              slv_req_vld,
    output bus_req_t [SLV_NUM-1:0]              slv_req,
    output logic     [MST_NUM-1:0]              mst_req_rdy
);

    // at most one master is locked to a slave
    always_comb begin
        slv_req_vld = '0;
        slv_req     = '0;
        for (int s = 0; s < SLV_NUM; s++) begin
            for (int m = 0; m < MST_NUM; m++) begin
                if (req_lock[m][s]) begin
                    slv_req_vld[s] = mst_req_vld[m];
                    slv_req[s]     = mst_req[m];
                end
            end
        end
    end

    // back pressure from the locked slave
    always_comb begin
        for (int m = 0; m < MST_NUM; m++) begin
            mst_req_rdy[m] = acc_fault[m] | (|(req_lock[m] & slv_req_rdy));
        end
    end

endmodule

//--- hw/bus_fab/rsp_router.sv
/* Response path: steers each slave's response to the master holding it
   and returns master ready. Also produces the registered fault response. */

`timescale 1ns/1ns

module rsp_router
    import bus_fab_pkg::*;
#(
    parameter int MST_NUM = 3,
    parameter int SLV_NUM = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic     [MST_NUM-1:0][SLV_NUM-1:0] rsp_lock,
    input  logic     [MST_NUM-1:0]              acc_fault,
    input  logic     [SLV_NUM-1:0]              slv_rsp_vld,
    input  bus_rsp_t [SLV_NUM-1:0]              slv_rsp,
    input  logic     [MST_NUM-1:0]              mst_rsp_rdy,
    output logic     [MST_NUM-1:0]              mst_rsp_vld,
    output bus_rsp_t [MST_NUM-1:0]              mst_rsp,
    output logic     [SLV_NUM-1:0]              slv_rsp_rdy,
    output logic     [SLV_NUM-1:0]              slv_rsp_fire
);

    logic [MST_NUM-1:0] fault_r;
    logic [MST_NUM-1:0] mst_rsp_fire;

    assign mst_rsp_fire = mst_rsp_vld & mst_rsp_rdy;

    // ************************************************************
    // fault response, pending until the master takes it
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_r <= '0;
        end else begin
            for (int m = 0; m < MST_NUM; m++) begin
                if (acc_fault[m]) begin
                    fault_r[m] <= 1'b1;
                end else if (mst_rsp_fire[m]) begin
                    fault_r[m] <= 1'b0;
                end
            end
        end
    end

    // slave to master
    always_comb begin
        mst_rsp_vld = '0;
        mst_rsp     = '0;
        for (int m = 0; m < MST_NUM; m++) begin
            for (int s = 0; s < SLV_NUM; s++) begin
                if (rsp_lock[m][s]) begin
                    mst_rsp_vld[m] = slv_rsp_vld[s];
                    mst_rsp[m]     = slv_rsp[s];
                end
            end
            if (fault_r[m]) begin
                mst_rsp_vld[m]  = 1'b1;
                mst_rsp[m].excp = EXCP_ACC_FAULT;
                mst_rsp[m].data = '0;
            end
        end
    end

    // master ready back to the held slave
    always_comb begin
        for (int s = 0; s < SLV_NUM; s++) begin
            slv_rsp_rdy[s] = 1'b0;
            for (int m = 0; m < MST_NUM; m++) begin
                slv_rsp_rdy[s] = slv_rsp_rdy[s] | (rsp_lock[m][s] & mst_rsp_rdy[m]);
            end
        end
    end

    assign slv_rsp_fire = slv_rsp_vld & slv_rsp_rdy;

endmodule

//--- hw/bus_fab/bus_fab_top.sv
/* Shared-bus fabric joining MST_NUM masters to SLV_NUM slaves.
   Wires the address decoder, the grant/lock control and both routers. */

`timescale 1ns/1ns

module bus_fab_top
    import bus_fab_pkg::*;
#(
    parameter int MST_NUM = 3,
    parameter int SLV_NUM = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // master ports
    input  logic     [MST_NUM-1:0]     mst_req_vld,
    output logic     [MST_NUM-1:0]     mst_req_rdy,
    input  bus_req_t [MST_NUM-1:0]     mst_req,
    output logic     [MST_NUM-1:0]     mst_rsp_vld,
    input  logic     [MST_NUM-1:0]     mst_rsp_rdy,
    output bus_rsp_t [MST_NUM-1:0]     mst_rsp,

    // slave ports
    output logic     [SLV_NUM-1:0]     slv_req_vld,
    input  logic     [SLV_NUM-1:0]     slv_req_rdy,
    output bus_req_t [SLV_NUM-1:0]     slv_req,
    input  logic     [SLV_NUM-1:0]     slv_rsp_vld,
    output logic     [SLV_NUM-1:0]     slv_rsp_rdy,
    input  bus_rsp_t [SLV_NUM-1:0]     slv_rsp
);

    logic [MST_NUM-1:0][SLV_NUM-1:0] addr_match;
    logic [MST_NUM-1:0]              acc_fault;
    logic [MST_NUM-1:0][SLV_NUM-1:0] req_lock;
    logic [MST_NUM-1:0][SLV_NUM-1:0] rsp_lock;
    logic [SLV_NUM-1:0]              slv_rsp_fire;

    addr_decode #(.MST_NUM(MST_NUM), .SLV_NUM(SLV_NUM)) u_addr_decode (
        .mst_req_vld (mst_req_vld),
        .mst_req     (mst_req),
        .addr_match  (addr_match),
        .acc_fault   (acc_fault)
    );

    bus_fab_ctrl #(.MST_NUM(MST_NUM), .SLV_NUM(SLV_NUM)) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .mst_req_vld  (mst_req_vld),
        .addr_match   (addr_match),
        .slv_rsp_fire (slv_rsp_fire),
        .req_lock     (req_lock),
        .rsp_lock     (rsp_lock)
    );

    req_router #(.MST_NUM(MST_NUM), .SLV_NUM(SLV_NUM)) u_req_router (
        .req_lock    (req_lock),
        .mst_req_vld (mst_req_vld),
        .mst_req     (mst_req),
        .slv_req_rdy (slv_req_rdy),
        .acc_fault   (acc_fault),
        .slv_req_vld (slv_req_vld),
        .slv_req     (slv_req),
        .mst_req_rdy (mst_req_rdy)
    );

    rsp_router #(.MST_NUM(MST_NUM), .SLV_NUM(SLV_NUM)) u_rsp_router (
        .clk          (clk),
        .rst_n        (rst_n),
        .rsp_lock     (rsp_lock),
        .acc_fault    (acc_fault),
        .slv_rsp_vld  (slv_rsp_vld),
        .slv_rsp      (slv_rsp),
        .mst_rsp_rdy  (mst_rsp_rdy),
        .mst_rsp_vld  (mst_rsp_vld),
        .mst_rsp      (mst_rsp),
        .slv_rsp_rdy  (slv_rsp_rdy),
        .slv_rsp_fire (slv_rsp_fire)
    );

endmodule

//--- tests/bus_fab_properties.sv
/* Handshake and lock assertions for the fabric, bound into bus_fab_top. */

`timescale 1ns/1ns

module bus_fab_properties
    import bus_fab_pkg::*;
#(
    parameter int MST_NUM = 3,
    parameter int SLV_NUM = 4
) (
    input logic                            clk,
    input logic                            rst_n,
    input logic     [MST_NUM-1:0]          mst_req_vld,
    input logic     [MST_NUM-1:0]          mst_req_rdy,
    input logic     [MST_NUM-1:0]          mst_rsp_vld,
    input logic     [MST_NUM-1:0]          mst_rsp_rdy,
    input logic     [SLV_NUM-1:0]          slv_req_vld,
    input logic     [SLV_NUM-1:0]          slv_req_rdy,
    input bus_req_t [SLV_NUM-1:0]          slv_req,
    input logic [MST_NUM-1:0][SLV_NUM-1:0] rsp_lock,
    input logic     [MST_NUM-1:0]          fault_r
);

    // held grants seen from the slave side
    logic [SLV_NUM-1:0][MST_NUM-1:0] held;
    // accepted request still waiting for its response
    logic [MST_NUM-1:0]              req_open;

    always_comb begin
        for (int s = 0; s < SLV_NUM; s++) begin
            for (int m = 0; m < MST_NUM; m++) begin
                held[s][m] = rsp_lock[m][s];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_open <= '0;
        end else begin
            req_open <= (req_open & ~(mst_rsp_vld & mst_rsp_rdy))
                      | (mst_req_vld & mst_req_rdy);
        end
    end

    for (genvar m = 0; m < MST_NUM; m++) begin : g_mst
        a_rsp_owner : assert property (@(posedge clk) disable iff (!rst_n)
            mst_rsp_vld[m] |-> req_open[m] && ((|rsp_lock[m]) || fault_r[m]))
            else $error("master %0d response valid with no lock and no fault", m);
    end

    for (genvar s = 0; s < SLV_NUM; s++) begin : g_slv
        a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
            slv_req_vld[s] && !slv_req_rdy[s] |=> slv_req_vld[s] && $stable(slv_req[s]))
            else $error("slave %0d request payload changed while stalled", s);

        a_one_grant : assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(held[s]))
            else $error("slave %0d has more than one held grant", s);
    end

endmodule

bind bus_fab_top bus_fab_properties #(.MST_NUM(MST_NUM), .SLV_NUM(SLV_NUM)) u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .mst_req_vld (mst_req_vld),
    .mst_req_rdy (mst_req_rdy),
    .mst_rsp_vld (mst_rsp_vld),
    .mst_rsp_rdy (mst_rsp_rdy),
    .slv_req_vld (slv_req_vld),
    .slv_req_rdy (slv_req_rdy),
    .slv_req     (slv_req),
    .rsp_lock    (rsp_lock),
    .fault_r     (u_rsp_router.fault_r)
);

//--- tests/bus_fab_checker.sv
/* Scoreboard for the fabric: predicts every master response from a
   reference memory and compares it when the response fires. */

`timescale 1ns/1ns

module bus_fab_checker
    import bus_fab_pkg::*;
#(
    parameter int MST_NUM = 3,
    parameter int SLV_NUM = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic     [MST_NUM-1:0] mst_req_vld,
    input  logic     [MST_NUM-1:0] mst_req_rdy,
    input  bus_req_t [MST_NUM-1:0] mst_req,
    input  logic     [MST_NUM-1:0] mst_rsp_vld,
    input  logic     [MST_NUM-1:0] mst_rsp_rdy,
    input  bus_rsp_t [MST_NUM-1:0] mst_rsp,
    input  logic     [SLV_NUM-1:0] slv_req_vld,
    input  logic     [SLV_NUM-1:0] slv_req_rdy,
    input  bus_req_t [SLV_NUM-1:0] slv_req,
    input  logic                   idle_chk,
    input  logic                   fair_en,
    output int                     err_cnt,
    output int                     rsp_cnt,
    output int                     slv_fire_cnt
);

    logic [DATA_W-1:0]  ref_mem [SLV_NUM][64];
    bus_rsp_t           exp_rsp [MST_NUM];
    logic [MST_NUM-1:0] pending;
    logic [MST_NUM-1:0] served;

    // same fill as the slave models, word value from the full address
    initial begin
        for (int s = 0; s < SLV_NUM; s++) begin
            for (int i = 0; i < 64; i++) begin
                ref_mem[s][i] = ((32'(s) << 28) | (32'(i) << 2)) ^ 32'h3c5a_96e1;
            end
        end
    end

    // expected response of one access, writes update the reference
    function automatic bus_rsp_t ref_access(input bus_req_t r);
        bus_rsp_t res;
        int       region;
        int       idx;
        region   = int'(r.addr[31:28]);
        idx      = int'(r.addr[7:2]);
        res.excp = EXCP_NONE;
        res.data = '0;
        if (region >= SLV_NUM) begin
            res.excp = EXCP_ACC_FAULT;
        end else if (r.read) begin
            res.data = ref_mem[region][idx];
        end else begin
            for (int b = 0; b < MASK_W; b++) begin
                if (r.mask[b]) begin
                    ref_mem[region][idx][8*b +: 8] = r.data[8*b +: 8];
                end
            end
        end
        return res;
    endfunction

    // ************************************************************
    // comparison
    // ************************************************************
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending      = '0;
            served       = '0;
            err_cnt      = 0;
            rsp_cnt      = 0;
            slv_fire_cnt = 0;
        end else begin
            if (idle_chk && (slv_req_vld != '0 || mst_rsp_vld != '0)) begin
                $display("CHECK FAILED slv_req_vld=0x%0h mst_rsp_vld=0x%0h expected 0x0",
                         slv_req_vld, mst_rsp_vld);
                err_cnt++;
            end
            for (int s = 0; s < SLV_NUM; s++) begin
                if (slv_req_vld[s] && slv_req_rdy[s]) begin
                    slv_fire_cnt++;
                    if (int'(slv_req[s].addr[31:28]) != s) begin
                        $display("slave %0d received a request for another region", s);
                        err_cnt++;
                    end
                end
            end
            if (!fair_en) begin
                served = '0;
            end
            for (int m = 0; m < MST_NUM; m++) begin
                if (mst_rsp_vld[m] && mst_rsp_rdy[m]) begin
                    rsp_cnt++;
                    if (!pending[m]) begin
                        $display("master %0d got a response with no request open", m);
                        err_cnt++;
                    end else if (mst_rsp[m] != exp_rsp[m]) begin
                        $display("CHECK FAILED mst_rsp[%0d] = 0x%09h expected 0x%09h",
                                 m, mst_rsp[m], exp_rsp[m]);
                        err_cnt++;
                    end
                    pending[m] = 1'b0;
                    if (fair_en) begin
                        if (served[m]) begin
                            $display("round-robin order broken, master %0d served twice", m);
                            err_cnt++;
                        end
                        served[m] = 1'b1;
                        if (&served) begin
                            served = '0;
                        end
                    end
                end
                if (mst_req_vld[m] && mst_req_rdy[m]) begin
                    exp_rsp[m] = ref_access(mst_req[m]);
                    pending[m] = 1'b1;
                end
            end
        end
    end

endmodule

//--- tests/bus_fab_tb.sv
/* Testbench top for the fabric: clock, reset, master stimulus and
   slave memory models around the DUT, with the checker attached. */

`timescale 1ns/1ns

module bus_fab_tb
    import bus_fab_pkg::*;
;

    localparam int MST_NUM = 3;
    localparam int SLV_NUM = 4;
    localparam int N_RAND  = 20;
    // directed 16 + fault 3 + fairness 12 + random
    localparam int TOTAL_TXN   = 16 + 3 + MST_NUM * 4 + MST_NUM * N_RAND;
    localparam int CYCLE_LIMIT = 40 * TOTAL_TXN;

    logic                   clk;
    logic                   rst_n;
    logic     [MST_NUM-1:0] mst_req_vld;
    logic     [MST_NUM-1:0] mst_req_rdy;
    bus_req_t [MST_NUM-1:0] mst_req;
    logic     [MST_NUM-1:0] mst_rsp_vld;
    logic     [MST_NUM-1:0] mst_rsp_rdy;
    bus_rsp_t [MST_NUM-1:0] mst_rsp;
    logic     [SLV_NUM-1:0] slv_req_vld;
    logic     [SLV_NUM-1:0] slv_req_rdy;
    bus_req_t [SLV_NUM-1:0] slv_req;
    logic     [SLV_NUM-1:0] slv_rsp_vld;
    logic     [SLV_NUM-1:0] slv_rsp_rdy;
    bus_rsp_t [SLV_NUM-1:0] slv_rsp;

    // per-master drive state
    logic     m_vld [MST_NUM];
    logic     m_rdy [MST_NUM];
    bus_req_t m_req [MST_NUM];

    logic idle_chk;
    logic fair_en;
    int   err_cnt;
    int   rsp_cnt;
    int   slv_fire_cnt;
    int   tb_err;
    int   txn_cnt;
    int   cycles;

    always_comb begin
        for (int m = 0; m < MST_NUM; m++) begin
            mst_req_vld[m] = m_vld[m];
            mst_req[m]     = m_req[m];
            mst_rsp_rdy[m] = m_rdy[m];
        end
    end

    bus_fab_top #(.MST_NUM(MST_NUM), .SLV_NUM(SLV_NUM)) u_dut (.*);

    bus_fab_checker #(.MST_NUM(MST_NUM), .SLV_NUM(SLV_NUM)) u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ************************************************************
    // slave memory models
    // ************************************************************
    for (genvar s = 0; s < SLV_NUM; s++) begin : g_slv
        logic              req_rdy;
        logic              rsp_vld;
        bus_rsp_t          rsp;
        logic [DATA_W-1:0] mem [64];

        assign slv_req_rdy[s] = req_rdy;
        assign slv_rsp_vld[s] = rsp_vld;
        assign slv_rsp[s]     = rsp;

        initial begin : model
            bus_req_t r;
            int       idx;
            req_rdy = 1'b0;
            rsp_vld = 1'b0;
            rsp     = '0;
            for (int i = 0; i < 64; i++) begin
                mem[i] = ((32'(s) << 28) | (32'(i) << 2)) ^ 32'h3c5a_96e1;
            end
            forever begin
                @(negedge clk);
                if (slv_req_vld[s]) begin
                    repeat ($urandom_range(3, 0)) @(negedge clk);
                    r       = slv_req[s];
                    req_rdy = 1'b1;
                    @(negedge clk);
                    req_rdy  = 1'b0;
                    idx      = int'(r.addr[7:2]);
                    rsp.excp = EXCP_NONE;
                    rsp.data = '0;
                    if (r.read) begin
                        rsp.data = mem[idx];
                    end else begin
                        for (int b = 0; b < MASK_W; b++) begin
                            if (r.mask[b]) mem[idx][8*b +: 8] = r.data[8*b +: 8];
                        end
                    end
                    repeat ($urandom_range(3, 0)) @(negedge clk);
                    rsp_vld = 1'b1;
                    do @(posedge clk); while (!slv_rsp_rdy[s]);
                    @(negedge clk);
                    rsp_vld = 1'b0;
                end
            end
        end
    end

    // ************************************************************
    // master side
    // ************************************************************
    task automatic run_txn(input int m, input bus_req_t r, input bit rand_rdy);
        bit done;
        done = 1'b0;
        @(negedge clk);
        m_vld[m] = 1'b1;
        m_req[m] = r;
        m_rdy[m] = 1'b0;
        do @(posedge clk); while (!mst_req_rdy[m]);
        @(negedge clk);
        m_vld[m] = 1'b0;
        m_rdy[m] = rand_rdy ? 1'($urandom_range(1, 0)) : 1'b1;
        while (!done) begin
            @(posedge clk);
            if (mst_rsp_vld[m] && mst_rsp_rdy[m]) begin
                done = 1'b1;
            end else begin
                @(negedge clk);
                if (rand_rdy) m_rdy[m] = 1'($urandom_range(1, 0));
            end
        end
        // let the checker settle on this edge
        @(negedge clk);
        txn_cnt++;
    endtask

    function automatic bus_req_t make_req(input bit rd, input int region, input int idx,
                                          input logic [MASK_W-1:0] mask,
                                          input logic [DATA_W-1:0] data);
        bus_req_t r;
        r.read = rd;
        r.addr = (32'(region) << 28) | (32'(idx) << 2);
        r.mask = mask;
        r.data = data;
        return r;
    endfunction

    task automatic random_traffic(input int m);
        for (int i = 0; i < N_RAND; i++) begin
            // region SLV_NUM now and then gives an unmapped access
            run_txn(m, make_req(1'($urandom_range(1, 0)), $urandom_range(SLV_NUM, 0),
                                $urandom_range(63, 0), 4'($urandom_range(15, 1)),
                                $urandom), 1'b1);
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
    endtask

    task automatic report_test(input int n, input string name);
        $display("test %0d %s done, errors %0d", n, name, err_cnt + tb_err);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d transactions done",
                     cycles, txn_cnt, TOTAL_TXN);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int fires;
        void'($urandom(43124));
        tb_err   = 0;
        txn_cnt  = 0;
        idle_chk = 1'b0;
        fair_en  = 1'b0;
        for (int m = 0; m < MST_NUM; m++) begin
            m_vld[m] = 1'b0;
            m_rdy[m] = 1'b0;
            m_req[m] = '0;
        end
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        idle_chk = 1'b1;
        repeat (10) @(negedge clk);
        idle_chk = 1'b0;
        report_test(1, "idle after reset");

        for (int s = 0; s < SLV_NUM; s++) begin
            run_txn(0, make_req(1'b0, s, 5, 4'b0101, 32'hdead_beef ^ 32'(s)), 1'b0);
            run_txn(0, make_req(1'b1, s, 5, 4'b0000, 32'h0), 1'b0);
            run_txn(0, make_req(1'b0, s, 40, 4'b1110, 32'h1234_5678 + 32'(s)), 1'b0);
            run_txn(0, make_req(1'b1, s, 40, 4'b0000, 32'h0), 1'b0);
        end
        report_test(2, "masked write and read back");

        fires = slv_fire_cnt;
        run_txn(1, make_req(1'b1, SLV_NUM, 3, 4'hf, 32'h0), 1'b0);
        run_txn(1, make_req(1'b0, 15, 9, 4'hf, 32'hffff_0000), 1'b0);
        run_txn(2, make_req(1'b1, 10, 0, 4'h1, 32'h0), 1'b1);
        if (slv_fire_cnt != fires) begin
            $display("a slave accepted a request for an unmapped address");
            tb_err++;
        end
        report_test(3, "unmapped access fault");

        fair_en = 1'b1;
        for (int m = 0; m < MST_NUM; m++) begin
            automatic int mm = m;
            fork
                for (int i = 0; i < 4; i++) begin
                    run_txn(mm, make_req(1'b1, 0, mm + i, 4'hf, 32'h0), 1'b0);
                end
            join_none
        end
        wait fork;
        @(negedge clk);
        fair_en = 1'b0;
        report_test(4, "round-robin fairness");

        for (int m = 0; m < MST_NUM; m++) begin
            automatic int mm = m;
            fork
                random_traffic(mm);
            join_none
        end
        wait fork;
        repeat (2) @(negedge clk);
        report_test(5, "random traffic");

        if (rsp_cnt != TOTAL_TXN) begin
            $display("response count %0d does not match %0d transactions", rsp_cnt, TOTAL_TXN);
            tb_err++;
        end
        $display("transactions %0d, responses %0d, errors %0d",
                 txn_cnt, rsp_cnt, err_cnt + tb_err);
        if (err_cnt + tb_err == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- list.f
common/bus_fab_pkg.sv
common/bus_map_pkg.sv
hw/bus_fab/rr_arbiter.sv
hw/bus_fab/addr_decode.sv
hw/bus_fab/bus_fab_ctrl.sv
hw/bus_fab/req_router.sv
hw/bus_fab/rsp_router.sv
hw/bus_fab/bus_fab_top.sv
tests/bus_fab_properties.sv
tests/bus_fab_checker.sv
tests/bus_fab_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= bus_fab_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
